// File: sources.f
verilog/dma_fifo_pkg.sv
verilog/fifo_ctrl.sv
verilog/fifo_lane_strobes.sv
verilog/fifo_pointers.sv
verilog/fifo_store.sv
verilog/dma_fifo_top.sv
verification/dma_fifo_properties.sv
verification/dma_fifo_tb.sv

// File: verification/dma_fifo_properties.sv
/* Concurrent checks on the FIFO flags, the occupancy count and the effect of a flush */
`timescale 1ns/1ps

module dma_fifo_properties #(
  parameter  int depth = 8,
  localparam int cnt_w = $clog2(depth) + 1
) (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     flush,
  input dma_fifo_pkg::byte_lane_t lane_sel,
  input logic                     full,
  input logic                     empty,
  input logic [cnt_w-1:0]         count        // From the pointer block
);

  int fail_count = 0;                          // Failed assertions so far

  full_empty_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(full && empty)) else begin
    fail_count++;
    $error("full and empty high together");
  end

  count_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    count <= cnt_w'(depth)) else begin
    fail_count++;
    $error("count above depth");
  end

  // Count, flags and byte pointer settle one edge after the CTRL write
  flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> (count == '0) && empty && !full && (lane_sel == '0)) else begin
    fail_count++;
    $error("flush did not clear the FIFO state");
  end

endmodule

// Control sees the pointer block's count and flags as inputs
bind fifo_ctrl dma_fifo_properties #(
  .depth    (depth)
) u_props (
  .clk      (clk),
  .arst_n   (arst_n),
  .flush    (flush),
  .lane_sel (lane_sel),
  .full     (full),
  .empty    (empty),
  .count    (count)
);

// File: verification/dma_fifo_tb.sv
/* Directed testbench of the byte-packing DMA FIFO against a queue model */
`timescale 1ns/1ps

module dma_fifo_tb;

  localparam int test_cycles   = 140;          // All tests, rounded up
  localparam int margin_cycles = 60;

  logic clk = 1'b0;
  logic arst_n, psel, penable, pwrite, pready, pslverr;
  logic load_lo, load_hi, push, byte_wr, pop, full, empty, bo_first, bo_last;
  logic [7:0] byte_data;
  dma_fifo_pkg::apb_addr_t  paddr;
  dma_fifo_pkg::longword_t  pwdata, prdata, wr_data, rd_data;
  dma_fifo_pkg::byte_lane_t byte_ptr;

  dma_fifo_pkg::longword_t  model_q [$];       // Committed entries with the head first
  dma_fifo_pkg::longword_t  slot_m [8];        // Shadow of the store slots
  logic [2:0]               tail_m;            // Model next-in index
  dma_fifo_pkg::byte_lane_t ptr_m;             // Model byte pointer
  dma_fifo_pkg::longword_t  lcg_state = 32'h399c;
  int errors = 0;
  int tests = 0;
  int errors_at_start = 0;

  dma_fifo_top #(.depth(8)) u_dut (.*);

  always #10 clk = ~clk;

  function automatic dma_fifo_pkg::longword_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // STATUS layout from the register map
  function automatic dma_fifo_pkg::longword_t status_exp();
    dma_fifo_pkg::longword_t w;
    w = '0;
    w[7:0]   = 8'(model_q.size());
    w[8]     = (model_q.size() == 8);
    w[9]     = (model_q.size() == 0);
    w[11:10] = ptr_m;
    return w;
  endfunction

  task automatic check_word(input string name, input dma_fifo_pkg::longword_t exp,
                            input dma_fifo_pkg::longword_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_lane(input string name, input dma_fifo_pkg::byte_lane_t exp,
                            input dma_fifo_pkg::byte_lane_t act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic tick();                       // To 2 ns after the next rising edge
    @(posedge clk);
    #2;
  endtask

  task automatic check_ptr();
    check_lane("byte_ptr", ptr_m, byte_ptr);
    check_flag("bo_first", ptr_m == 2'd0, bo_first);
    check_flag("bo_last", ptr_m == 2'd3, bo_last);
  endtask

  task automatic compare_flags();
    @(negedge clk);
    check_flag("full", model_q.size() == 8, full);
    check_flag("empty", model_q.size() == 0, empty);
    check_ptr();
    tick();
  endtask

  task automatic commit_entry();
    if (model_q.size() < 8) begin              // Dropped when full
      model_q.push_back(slot_m[tail_m]);
      tail_m++;
    end
  endtask

  task automatic apb_write(input dma_fifo_pkg::apb_addr_t addr,
                           input dma_fifo_pkg::longword_t data, input logic exp_err);
    psel   = 1'b1;                             // Setup phase
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    tick();
    penable = 1'b1;
    @(negedge clk);
    check_flag("pready", 1'b1, pready);
    check_flag("pslverr", exp_err, pslverr);
    tick();                                    // Write lands at this edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (!exp_err && addr == dma_fifo_pkg::ADDR_CTRL && data[0]) begin
      model_q.delete();
      tail_m = '0;
      ptr_m  = '0;
    end else if (!exp_err && addr == dma_fifo_pkg::ADDR_ACR) begin
      ptr_m = data[1:0];
    end
  endtask

  task automatic apb_read(input dma_fifo_pkg::apb_addr_t addr, input logic exp_err,
                          output dma_fifo_pkg::longword_t data);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    tick();
    penable = 1'b1;
    @(negedge clk);
    check_flag("pready", 1'b1, pready);
    check_flag("pslverr", exp_err, pslverr);
    data = prdata;                             // Valid in the access phase
    tick();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_status();
    dma_fifo_pkg::longword_t rd;
    apb_read(dma_fifo_pkg::ADDR_STATUS, 1'b0, rd);
    check_word("STATUS", status_exp(), rd);
  endtask

  task automatic load_word(input dma_fifo_pkg::longword_t data);
    wr_data = data;
    load_lo = 1'b1;                            // Lower half-word
    tick();
    load_lo = 1'b0;
    load_hi = 1'b1;
    tick();
    load_hi = 1'b0;
    slot_m[tail_m] = data;
  endtask

  task automatic cpu_push_word(input dma_fifo_pkg::longword_t data);
    load_word(data);
    push = 1'b1;
    tick();
    push = 1'b0;
    commit_entry();
  endtask

  task automatic scsi_write_byte(input logic [7:0] data);
    byte_data = data;
    byte_wr   = 1'b1;
    @(negedge clk);
    check_ptr();
    tick();
    byte_wr = 1'b0;
    slot_m[tail_m][8*ptr_m +: 8] = data;       // Lane chosen by the pointer
    if (ptr_m == 2'd3) commit_entry();         // Last lane completes the entry
    ptr_m++;
  endtask

  task automatic pop_word();
    pop = 1'b1;
    @(negedge clk);
    if (model_q.size() > 0) check_word("rd_data", model_q[0], rd_data);
    tick();
    pop = 1'b0;
    if (model_q.size() > 0) void'(model_q.pop_front());  // Ignored when empty
  endtask

  task automatic push_pop_word(input dma_fifo_pkg::longword_t data);
    load_word(data);
    push = 1'b1;
    pop  = 1'b1;
    @(negedge clk);
    check_word("rd_data", model_q[0], rd_data);
    tick();
    push = 1'b0;
    pop  = 1'b0;
    void'(model_q.pop_front());
    commit_entry();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s done, %0d errors", tests, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial begin
    dma_fifo_pkg::longword_t rd;
    dma_fifo_pkg::longword_t w;
    arst_n    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    wr_data   = '0;
    load_lo   = 1'b0;
    load_hi   = 1'b0;
    push      = 1'b0;
    byte_data = '0;
    byte_wr   = 1'b0;
    pop       = 1'b0;
    tail_m    = '0;
    ptr_m     = '0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    tick();

    compare_flags();
    check_word("prdata", '0, prdata);          // Idle bus
    check_flag("pready", 1'b0, pready);
    check_flag("pslverr", 1'b0, pslverr);
    check_status();
    end_test("reset");

    repeat (8) cpu_push_word(lcg_next());
    compare_flags();
    push = 1'b1;                               // Push strobe alone on a full FIFO
    tick();
    push = 1'b0;
    commit_entry();
    check_status();
    repeat (8) pop_word();
    compare_flags();
    pop_word();
    compare_flags();
    end_test("word path");

    apb_write(dma_fifo_pkg::ADDR_ACR, 32'h0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      w = lcg_next();
      scsi_write_byte(w[7:0]);
    end
    compare_flags();                           // Pointer back at lane 0
    pop_word();
    end_test("byte packing");

    apb_write(dma_fifo_pkg::ADDR_ACR, 32'h2, 1'b0);
    apb_read(dma_fifo_pkg::ADDR_ACR, 1'b0, rd);
    check_word("ACR", 32'h2, rd);
    w = lcg_next();
    scsi_write_byte(w[7:0]);
    compare_flags();                           // Only lane 2 written and nothing committed
    scsi_write_byte(w[15:8]);
    compare_flags();
    pop_word();                                // Lanes 0-1 keep the old slot bytes
    end_test("ACR preset");

    cpu_push_word(lcg_next());
    cpu_push_word(lcg_next());
    w = lcg_next();
    scsi_write_byte(w[7:0]);
    apb_write(dma_fifo_pkg::ADDR_CTRL, 32'h1, 1'b0);
    compare_flags();
    check_status();
    apb_write(dma_fifo_pkg::ADDR_STATUS, '0, 1'b1);
    apb_write(8'h10, '0, 1'b1);
    apb_read(8'h10, 1'b1, rd);
    compare_flags();
    end_test("flush and APB errors");

    repeat (4) cpu_push_word(lcg_next());
    push_pop_word(lcg_next());
    check_status();                            // Count stays at 4
    repeat (4) pop_word();
    compare_flags();
    end_test("push with pop");

    errors += u_dut.u_ctrl.u_props.fail_count;
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((test_cycles + margin_cycles) * 20);
    $display("Timeout, the tests did not finish in %0d cycles", test_cycles + margin_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog/dma_fifo_pkg.sv
/* Shared types and APB register map of the SCSI DMA byte-packing FIFO */

package dma_fifo_pkg;

  // One FIFO entry or CPU data word
  typedef logic [31:0] longword_t;

  // Byte pointer and lane index
  // 0 selects bits 7:0, 3 selects bits 31:24
  typedef logic [1:0] byte_lane_t;

  // Per-lane write enables, bit n enables byte lane n
  typedef logic [3:0] lane_en_t;

  // APB register offset
  typedef logic [7:0] apb_addr_t;

  // Control register, bit 0 written as 1 flushes the FIFO
  localparam apb_addr_t ADDR_CTRL = 8'h00;

  // Status register, read only
  //   7:0   occupancy count
  //   8     full
  //   9     empty
  //   11:10 byte pointer
  localparam apb_addr_t ADDR_STATUS = 8'h04;

  // Auxiliary control register
  // Bits 1:0 preset the byte pointer and read it back
  localparam apb_addr_t ADDR_ACR = 8'h0C;

endpackage

// File: verilog/dma_fifo_top.sv
/* Byte-packing FIFO of the SCSI DMA controller, word-wide CPU side and
   byte-wide SCSI side with an APB register slave */
`timescale 1ns/1ps

module dma_fifo_top #(
  parameter int depth = 8                      // Entries, power of two
) (
  input  logic                     clk,
  input  logic                     arst_n,
  // APB register slave
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  dma_fifo_pkg::apb_addr_t  paddr,
  input  dma_fifo_pkg::longword_t  pwdata,
  output dma_fifo_pkg::longword_t  prdata,
  output logic                     pready,
  output logic                     pslverr,
  // CPU side
  input  dma_fifo_pkg::longword_t  wr_data,
  input  logic                     load_lo,    // Load lanes 0-1
  input  logic                     load_hi,    // Load lanes 2-3
  input  logic                     push,       // Commit the tail entry
  // SCSI side
  input  logic [7:0]               byte_data,
  input  logic                     byte_wr,    // Write one byte at the pointer
  // Read side
  input  logic                     pop,
  output dma_fifo_pkg::longword_t  rd_data,    // Head entry
  // Flags
  output logic                     full,
  output logic                     empty,
  output dma_fifo_pkg::byte_lane_t byte_ptr,
  output logic                     bo_first,   // Pointer at lane 0
  output logic                     bo_last     // Pointer at lane 3
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = ptr_w + 1;            // Count reaches depth

  logic                    commit;
  logic                    take;
  logic                    flush;
  logic [cnt_w-1:0]        count;
  logic [ptr_w-1:0]        wr_idx;
  logic [ptr_w-1:0]        rd_idx;
  dma_fifo_pkg::lane_en_t  lane_en;
  dma_fifo_pkg::longword_t lane_data;

  // Registers, byte pointer and push/pop gating
  fifo_ctrl #(
    .depth    (depth)
  ) u_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .push     (push),
    .pop      (pop),
    .byte_wr  (byte_wr),
    .count    (count),
    .full     (full),
    .empty    (empty),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .lane_sel (byte_ptr),                      // Pointer also drives the flag port
    .commit   (commit),
    .take     (take),
    .flush    (flush),
    .bo_first (bo_first),
    .bo_last  (bo_last)
  );

  fifo_lane_strobes u_lanes (
    .wr_data   (wr_data),
    .byte_data (byte_data),
    .load_lo   (load_lo),
    .load_hi   (load_hi),
    .byte_wr   (byte_wr),
    .lane_sel  (byte_ptr),
    .lane_en   (lane_en),
    .lane_data (lane_data)
  );

  fifo_pointers #(
    .depth  (depth)
  ) u_ptrs (
    .clk    (clk),
    .arst_n (arst_n),
    .commit (commit),
    .take   (take),
    .flush  (flush),
    .wr_idx (wr_idx),
    .rd_idx (rd_idx),
    .count  (count),
    .full   (full),
    .empty  (empty)
  );

  fifo_store #(
    .depth     (depth)
  ) u_store (
    .clk       (clk),
    .lane_en   (lane_en),
    .lane_data (lane_data),
    .wr_idx    (wr_idx),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data)
  );

endmodule

// File: verilog/fifo_ctrl.sv
/* FIFO control: APB register slave, flush, byte pointer and the gated
   commit and take toward the pointer block */
`timescale 1ns/1ps

module fifo_ctrl #(
  parameter  int depth = 8,
  localparam int cnt_w = $clog2(depth) + 1
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  dma_fifo_pkg::apb_addr_t  paddr,
  input  dma_fifo_pkg::longword_t  pwdata,
  input  logic                     push,
  input  logic                     pop,
  input  logic                     byte_wr,
  input  logic [cnt_w-1:0]         count,
  input  logic                     full,
  input  logic                     empty,
  output dma_fifo_pkg::longword_t  prdata,
  output logic                     pready,
  output logic                     pslverr,
  output dma_fifo_pkg::byte_lane_t lane_sel,
  output logic                     commit,
  output logic                     take,
  output logic                     flush,
  output logic                     bo_first,
  output logic                     bo_last
);

  logic                     access;            // APB access phase
  logic                     mapped;
  logic                     ro_write;          // Write to read-only STATUS
  logic                     reg_wr;            // Accepted register write
  logic                     acr_wr;
  dma_fifo_pkg::longword_t  rd_word;
  dma_fifo_pkg::byte_lane_t byte_ptr_q;

  assign access   = psel & penable;
  assign pready   = access;                    // No wait states
  assign ro_write = pwrite & (paddr == dma_fifo_pkg::ADDR_STATUS);
  assign pslverr  = access & (~mapped | ro_write);
  assign reg_wr   = access & pwrite & ~pslverr;

  // Flush is a pulse, pointers clear at the end of the access phase
  assign flush  = reg_wr & (paddr == dma_fifo_pkg::ADDR_CTRL) & pwdata[0];
  assign acr_wr = reg_wr & (paddr == dma_fifo_pkg::ADDR_ACR);

  // Address decode and read mux
  always_comb begin
    mapped  = 1'b1;
    rd_word = '0;
    case (paddr)
      dma_fifo_pkg::ADDR_CTRL: begin
        rd_word = '0;                          // Flush bit is self-clearing
      end
      dma_fifo_pkg::ADDR_STATUS: begin
        rd_word[cnt_w-1:0] = count;
        rd_word[8]         = full;
        rd_word[9]         = empty;
        rd_word[11:10]     = byte_ptr_q;
      end
      dma_fifo_pkg::ADDR_ACR: begin
        rd_word[1:0] = byte_ptr_q;
      end
      default: begin
        mapped = 1'b0;                         // Unmapped offset
      end
    endcase
  end

  assign prdata = access ? rd_word : '0;       // Quiet outside the access phase

  // Byte pointer
  // Flush beats an ACR preset, which beats a byte write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_ptr_q <= '0;
    end else if (flush) begin
      byte_ptr_q <= '0;
    end else if (acr_wr) begin
      byte_ptr_q <= pwdata[1:0];               // Preset from the ACR
    end else if (byte_wr) begin
      byte_ptr_q <= byte_ptr_q + 2'd1;         // Wraps 3 to 0
    end
  end

  assign lane_sel = byte_ptr_q;
  assign bo_first = (byte_ptr_q == 2'd0);
  assign bo_last  = (byte_ptr_q == 2'd3);

  // The only place that checks full and empty
  // A byte into lane 3 completes the entry
  assign commit = (push | (byte_wr & bo_last)) & ~full;
  assign take   = pop & ~empty;

endmodule

// File: verilog/fifo_lane_strobes.sv
/* Lane write decode, turns word loads and byte writes into byte-lane
   enables and the merged lane data */
`timescale 1ns/1ps

module fifo_lane_strobes (
  input  dma_fifo_pkg::longword_t  wr_data,
  input  logic [7:0]               byte_data,
  input  logic                     load_lo,
  input  logic                     load_hi,
  input  logic                     byte_wr,
  input  dma_fifo_pkg::byte_lane_t lane_sel,
  output dma_fifo_pkg::lane_en_t   lane_en,
  output dma_fifo_pkg::longword_t  lane_data
);

  always_comb begin
    lane_en   = '0;
    lane_data = wr_data;                       // Word loads take the CPU data
    if (byte_wr) begin
      // SCSI byte wins over any word load this cycle
      lane_en[lane_sel]                    = 1'b1;
      lane_data[{lane_sel, 3'b000} +: 8]   = byte_data;
    end else begin
      if (load_lo) begin
        lane_en[1:0] = 2'b11;                  // Lower half-word
      end
      if (load_hi) begin
        lane_en[3:2] = 2'b11;                  // Upper half-word
      end
    end
  end

endmodule

// File: verilog/fifo_pointers.sv
/* Next-in and next-out pointers with the occupancy counter and the
   registered full and empty flags */
`timescale 1ns/1ps

module fifo_pointers #(
  parameter  int depth = 8,
  localparam int ptr_w = $clog2(depth),
  localparam int cnt_w = ptr_w + 1
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             commit,             // Already gated against full
  input  logic             take,               // Already gated against empty
  input  logic             flush,
  output logic [ptr_w-1:0] wr_idx,             // Next in
  output logic [ptr_w-1:0] rd_idx,             // Next out
  output logic [cnt_w-1:0] count,
  output logic             full,
  output logic             empty
);

  logic [cnt_w-1:0] count_nxt;

  // Occupancy after this edge
  always_comb begin
    case ({commit, take})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;              // Both or neither, no change
    endcase
    if (flush) begin
      count_nxt = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (flush) begin
        wr_idx <= '0;
        rd_idx <= '0;
      end else begin
        if (commit) wr_idx <= wr_idx + 1'b1;   // Wraps at depth
        if (take)   rd_idx <= rd_idx + 1'b1;
      end
      count <= count_nxt;
      // Flags follow the new count
      full  <= (count_nxt == cnt_w'(depth));
      empty <= (count_nxt == '0);
    end
  end

endmodule

// File: verilog/fifo_store.sv
/* Longword storage of the FIFO, per-lane writes into the tail slot and a
   combinational read of the head slot */
`timescale 1ns/1ps

module fifo_store #(
  parameter  int depth = 8,
  localparam int ptr_w = $clog2(depth)
) (
  input  logic                    clk,
  input  dma_fifo_pkg::lane_en_t  lane_en,
  input  dma_fifo_pkg::longword_t lane_data,
  input  logic [ptr_w-1:0]        wr_idx,      // Tail slot
  input  logic [ptr_w-1:0]        rd_idx,      // Head slot
  output dma_fifo_pkg::longword_t rd_data
);

  dma_fifo_pkg::longword_t mem [depth];        // Payload only

  // Each byte lane is written on its own
  // An entry may be built over several cycles
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (lane_en[i]) begin
        mem[wr_idx][8*i +: 8] <= lane_data[8*i +: 8];
      end
    end
  end

  // Head entry, follows rd_idx in the same cycle
  assign rd_data = mem[rd_idx];

endmodule
